/* issue_pkg.sv */
// Shared sizes and bundles of the issue stage
// Tag width is fixed by NUM_TAGS, so num_tags above 8 needs a wider tag_t
package issue_pkg;

    // ################################################
    // Sizes
    // ################################################

    // Tags, table entries and wait slots
    localparam int unsigned NUM_TAGS  = 8;
    localparam int unsigned REG_IDX_W = 6;
    localparam int unsigned SUBWARP_W = 2;
    // Sources per instruction, fixed
    localparam int unsigned NUM_OPS   = 2;
    localparam int unsigned TAG_W_MAX = $clog2(NUM_TAGS);

    typedef logic [TAG_W_MAX-1:0] tag_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ################################################
    // Bundles
    // ################################################

    // Decoded instruction from the decoder
    typedef struct packed {
        logic [SUBWARP_W-1:0]      subwarp;
        reg_idx_t                  dst;
        reg_idx_t [NUM_OPS-1:0]    src;
    } inst_t;

    // Issued instruction towards the EU
    typedef struct packed {
        tag_t                 tag;
        logic [SUBWARP_W-1:0] subwarp;
        reg_idx_t             dst;
    } dispatch_t;

    // EU writeback strobe
    typedef struct packed {
        logic valid;
        tag_t tag;
    } wb_t;

endpackage

/* tag_pool.sv */
// Free list of producer tags, lowest free tag is offered first
// A tag comes back only through writeback, never on dispatch
module tag_pool #(
    parameter int unsigned num_tags = issue_pkg::NUM_TAGS
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            alloc_i,
    input  issue_pkg::wb_t  wb_i,
    output logic            empty_o,
    output issue_pkg::tag_t alloc_tag_o
);

    // One bit per tag, set while free
    logic [num_tags-1:0] free_q;
    logic                found;

    // ################################################
    // Lowest free tag
    // ################################################

    always_comb begin
        found       = 1'b0;
        alloc_tag_o = '0;
        for (int i = 0; i < num_tags; i++) begin
            if (free_q[i] && !found) begin
                found       = 1'b1;
                alloc_tag_o = issue_pkg::tag_t'(i);
            end
        end
    end

    // Nothing free means no new instruction
    assign empty_o = !found;

    // ################################################
    // Bitmap update
    // ################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            free_q <= '1;
        end else begin
            // Allocated tag and written-back tag never collide
            if (alloc_i) begin
                free_q[alloc_tag_o] <= 1'b0;
            end
            if (wb_i.valid) begin
                free_q[wb_i.tag] <= 1'b1;
            end
        end
    end

    // Decoder must watch space_available_o
    assert property (@(posedge clk_i) disable iff (!rst_n_i) alloc_i |-> !empty_o)
        else $error("tag allocated while pool empty");

    // EU returns only tags that are out
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.valid |-> !free_q[wb_i.tag])
        else $error("writeback of free tag %0d", wb_i.tag);

endmodule

/* reg_table.sv */
// Maps each (subwarp, register) to the tag of its latest pending producer
// Lookup outputs are valid every cycle, but only sampled on insert
module reg_table #(
    parameter int unsigned num_tags = issue_pkg::NUM_TAGS
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        insert_i,
    input  issue_pkg::inst_t                            inst_i,
    input  issue_pkg::tag_t                             tag_i,
    input  issue_pkg::wb_t                              wb_i,
    output logic                                        full_o,
    output logic                                        empty_o,
    output logic            [issue_pkg::NUM_OPS-1:0]    ops_ready_o,
    output issue_pkg::tag_t [issue_pkg::NUM_OPS-1:0]    ops_tag_o
);

    // One entry per pending destination
    typedef struct packed {
        logic [issue_pkg::SUBWARP_W-1:0] subwarp;
        issue_pkg::reg_idx_t             dst;
        issue_pkg::tag_t                 producer;
    } entry_t;

    logic   [num_tags-1:0] valid_q;
    logic   [num_tags-1:0] valid_d;
    entry_t [num_tags-1:0] entry_q;
    entry_t [num_tags-1:0] entry_d;

    // Destination already tracked
    logic hit;
    // Destination stored somewhere
    logic done;

    assign full_o  = &valid_q;
    assign empty_o = ~|valid_q;

    // ################################################
    // Operand lookup
    // ################################################

    always_comb begin
        ops_ready_o = '1;
        ops_tag_o   = '0;
        for (int op = 0; op < issue_pkg::NUM_OPS; op++) begin
            // First matching entry gives the producer
            for (int e = 0; e < num_tags; e++) begin
                if (ops_ready_o[op] && valid_q[e]
                    && entry_q[e].subwarp == inst_i.subwarp
                    && entry_q[e].dst == inst_i.src[op]) begin
                    ops_ready_o[op] = 1'b0;
                    ops_tag_o[op]   = entry_q[e].producer;
                end
            end
            // Producer writing back right now
            if (!ops_ready_o[op] && wb_i.valid && wb_i.tag == ops_tag_o[op]) begin
                ops_ready_o[op] = 1'b1;
            end
        end
    end

    // ################################################
    // Writeback clear and destination insert
    // ################################################

    always_comb begin
        valid_d = valid_q;
        entry_d = entry_q;
        hit     = 1'b0;
        done    = 1'b0;

        // Clear first, so a WAW update is not wiped by the old producer
        if (wb_i.valid) begin
            for (int e = 0; e < num_tags; e++) begin
                if (valid_q[e] && entry_q[e].producer == wb_i.tag) begin
                    valid_d[e] = 1'b0;
                end
            end
        end

        if (insert_i) begin
            // Existing destination takes the new producer
            for (int e = 0; e < num_tags; e++) begin
                if (!hit && valid_d[e]
                    && entry_d[e].subwarp == inst_i.subwarp
                    && entry_d[e].dst == inst_i.dst) begin
                    hit                 = 1'b1;
                    entry_d[e].producer = tag_i;
                end
            end
            done = hit;
            // Otherwise lowest free entry
            for (int e = 0; e < num_tags; e++) begin
                if (!done && !valid_d[e]) begin
                    done                = 1'b1;
                    valid_d[e]          = 1'b1;
                    entry_d[e].subwarp  = inst_i.subwarp;
                    entry_d[e].dst      = inst_i.dst;
                    entry_d[e].producer = tag_i;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Entry fields are qualified by valid_q
    always_ff @(posedge clk_i) begin
        entry_q <= entry_d;
    end

    // ################################################
    // Checks
    // ################################################

    assert property (@(posedge clk_i) disable iff (!rst_n_i) insert_i |-> !full_o)
        else $error("insert into full register table");

    // One entry per destination and subwarp
    for (genvar i = 0; i < num_tags; i++) begin : gen_uniq_i
        for (genvar j = i + 1; j < num_tags; j++) begin : gen_uniq_j
            assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !(valid_q[i] && valid_q[j]
                  && entry_q[i].dst == entry_q[j].dst
                  && entry_q[i].subwarp == entry_q[j].subwarp))
                else $error("entries %0d and %0d share dst %0d", i, j, entry_q[i].dst);
        end
    end

endmodule

/* wait_buffer.sv */
// Tag-indexed wait slots, lowest ready slot is dispatched each cycle
// Dispatch cannot be stalled, the EU must take every pulse
module wait_buffer #(
    parameter int unsigned num_tags = issue_pkg::NUM_TAGS
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        insert_i,
    input  issue_pkg::inst_t                            inst_i,
    input  issue_pkg::tag_t                             tag_i,
    input  logic            [issue_pkg::NUM_OPS-1:0]    ops_ready_i,
    input  issue_pkg::tag_t [issue_pkg::NUM_OPS-1:0]    ops_tag_i,
    input  issue_pkg::wb_t                              wb_i,
    output logic                                        empty_o,
    output logic                                        dispatch_valid_o,
    output issue_pkg::dispatch_t                        dispatch_o
);

    // Slot payload, operand tags are only meaningful while not ready
    typedef struct packed {
        logic [issue_pkg::SUBWARP_W-1:0]           subwarp;
        issue_pkg::reg_idx_t                       dst;
        issue_pkg::tag_t [issue_pkg::NUM_OPS-1:0]  op_tag;
    } slot_t;

    logic  [num_tags-1:0]                          valid_q;
    logic  [num_tags-1:0][issue_pkg::NUM_OPS-1:0]  op_ready_q;
    slot_t [num_tags-1:0]                          slot_q;

    logic            pick_valid;
    issue_pkg::tag_t pick_tag;

    assign empty_o = ~|valid_q;

    // ################################################
    // Lowest ready slot
    // ################################################

    always_comb begin
        pick_valid = 1'b0;
        pick_tag   = '0;
        for (int i = 0; i < num_tags; i++) begin
            if (!pick_valid && valid_q[i] && &op_ready_q[i]) begin
                pick_valid = 1'b1;
                pick_tag   = issue_pkg::tag_t'(i);
            end
        end
    end

    // ################################################
    // Slot state
    // ################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q          <= '0;
            op_ready_q       <= '0;
            dispatch_valid_o <= 1'b0;
        end else begin
            dispatch_valid_o <= pick_valid;
            // Picked slot leaves, its tag stays out until writeback
            if (pick_valid) begin
                valid_q[pick_tag] <= 1'b0;
            end
            // Wake operands waiting on the written-back tag
            if (wb_i.valid) begin
                for (int i = 0; i < num_tags; i++) begin
                    for (int op = 0; op < issue_pkg::NUM_OPS; op++) begin
                        if (slot_q[i].op_tag[op] == wb_i.tag) begin
                            op_ready_q[i][op] <= 1'b1;
                        end
                    end
                end
            end
            // New instruction, forwarding already done by the table
            if (insert_i) begin
                valid_q[tag_i]    <= 1'b1;
                op_ready_q[tag_i] <= ops_ready_i;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk_i) begin
        if (insert_i) begin
            slot_q[tag_i].subwarp <= inst_i.subwarp;
            slot_q[tag_i].dst     <= inst_i.dst;
            slot_q[tag_i].op_tag  <= ops_tag_i;
        end
        if (pick_valid) begin
            dispatch_o.tag     <= pick_tag;
            dispatch_o.subwarp <= slot_q[pick_tag].subwarp;
            dispatch_o.dst     <= slot_q[pick_tag].dst;
        end
    end

    // Slot must be empty when its tag is handed out again
    assert property (@(posedge clk_i) disable iff (!rst_n_i) insert_i |-> !valid_q[tag_i])
        else $error("insert into occupied slot %0d", tag_i);

endmodule

/* issue_stage.sv */
// Issue stage top: tag pool, register table and wait buffer
// Decoder may strobe insert_i only while space_available_o is high
module issue_stage #(
    parameter int unsigned num_tags = issue_pkg::NUM_TAGS
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 insert_i,
    input  issue_pkg::inst_t     inst_i,
    input  issue_pkg::wb_t       wb_i,
    output logic                 space_available_o,
    output logic                 all_dst_written_o,
    output logic                 dispatch_valid_o,
    output issue_pkg::dispatch_t dispatch_o
);

    logic                                     pool_empty;
    logic                                     tbl_full;
    logic                                     tbl_empty;
    issue_pkg::tag_t                          alloc_tag;
    logic            [issue_pkg::NUM_OPS-1:0] ops_ready;
    issue_pkg::tag_t [issue_pkg::NUM_OPS-1:0] ops_tag;

    // A tag at most one entry, so table not full is enough
    assign space_available_o = !pool_empty && !tbl_full;
    assign all_dst_written_o = tbl_empty;

    tag_pool #(.num_tags(num_tags)) u_tag_pool (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alloc_i     (insert_i),
        .wb_i        (wb_i),
        .empty_o     (pool_empty),
        .alloc_tag_o (alloc_tag)
    );

    reg_table #(.num_tags(num_tags)) u_reg_table (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .insert_i    (insert_i),
        .inst_i      (inst_i),
        .tag_i       (alloc_tag),
        .wb_i        (wb_i),
        .full_o      (tbl_full),
        .empty_o     (tbl_empty),
        .ops_ready_o (ops_ready),
        .ops_tag_o   (ops_tag)
    );

    wait_buffer #(.num_tags(num_tags)) u_wait_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .insert_i         (insert_i),
        .inst_i           (inst_i),
        .tag_i            (alloc_tag),
        .ops_ready_i      (ops_ready),
        .ops_tag_i        (ops_tag),
        .wb_i             (wb_i),
        .empty_o          (),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_o       (dispatch_o)
    );

endmodule

/* tb_issue_stage.sv */
// Testbench for issue_stage, reads issue_testdata.txt relative to the run directory
// Model predicts the lowest free tag and tracks pending destinations per subwarp
module tb_issue_stage;

    localparam int unsigned NUM_TAGS = issue_pkg::NUM_TAGS;
    localparam int          MAX_CMDS = 64;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 insert_i;
    issue_pkg::inst_t     inst_i;
    issue_pkg::wb_t       wb_i;
    logic                 space_available_o;
    logic                 all_dst_written_o;
    logic                 dispatch_valid_o;
    issue_pkg::dispatch_t dispatch_o;

    // Command words and run counters
    logic [31:0] cmds [0:MAX_CMDS-1];
    int          n_cmds;
    int          cmd_idx;
    int          idle_cnt;
    int          hold_cnt;
    int          cyc;
    int          wd_cycles;
    int          limit;
    int          errors;
    int          checks;
    int          n_fwd;
    int          n_ins;
    logic [31:0] lfsr;

    // Model state per tag
    bit busy     [NUM_TAGS];
    bit sent     [NUM_TAGS];
    int m_sw     [NUM_TAGS];
    int m_dst    [NUM_TAGS];
    bit dep_v    [NUM_TAGS][2];
    int dep_t    [NUM_TAGS][2];
    int ready_at [NUM_TAGS];
    int due      [NUM_TAGS];
    int eu_q     [$];
    // Latest producer per subwarp and register, key is subwarp*64+reg
    bit pend_v   [256];
    int pend_t   [256];

    issue_stage #(.num_tags(NUM_TAGS)) u_dut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .insert_i          (insert_i),
        .inst_i            (inst_i),
        .wb_i              (wb_i),
        .space_available_o (space_available_o),
        .all_dst_written_o (all_dst_written_o),
        .dispatch_valid_o  (dispatch_valid_o),
        .dispatch_o        (dispatch_o)
    );

    always #50 clk_i = ~clk_i;

    // ################################################
    // Helpers
    // ################################################

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int n_busy();
        int n;
        n = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            n += busy[i];
        end
        return n;
    endfunction

    function automatic int n_pend();
        int n;
        n = 0;
        for (int k = 0; k < 256; k++) begin
            n += pend_v[k];
        end
        return n;
    endfunction

    // -1 when every tag is out
    function automatic int lowest_free();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (!busy[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Lowest waiting tag whose operands were all ready two edges back
    function automatic int lowest_ready(input int now);
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (busy[i] && !sent[i] && !dep_v[i][0] && !dep_v[i][1]
                && ready_at[i] <= now - 2) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ################################################
    // One clock edge: check, update model, drive
    // ################################################

    task automatic run_cycle();
        int          t;
        int          key;
        int          lat;
        int          new_tag;
        int          exp_tag;
        int          qi;
        bit          wb_nx_v;
        int          wb_nx_t;
        bit          ins_nx;
        bit          fwd_ok;
        logic [31:0] cmd;

        cyc++;
        // Outputs before this edge against the model after the last one
        check(space_available_o, int'(n_busy() < NUM_TAGS && n_pend() < NUM_TAGS),
              "space_available_o");
        check(all_dst_written_o, int'(n_pend() == 0), "all_dst_written_o");

        // Slot picked on the previous edge
        exp_tag = lowest_ready(cyc);
        check(dispatch_valid_o, int'(exp_tag >= 0), "dispatch_valid_o");

        // Dispatch was registered on the previous edge
        if (dispatch_valid_o) begin
            t = dispatch_o.tag;
            check(t, exp_tag, "dispatch tag");
            check(int'(busy[t] && !sent[t]), 1, $sformatf("tag %0d in flight, not sent", t));
            check(dispatch_o.subwarp, m_sw[t], "dispatch subwarp");
            check(dispatch_o.dst, m_dst[t], "dispatch dst");
            check(int'(dep_v[t][0] || dep_v[t][1]), 0, $sformatf("tag %0d producers done", t));
            sent[t] = 1'b1;
            // Two LFSR bits give latency 1 to 4
            lfsr = lfsr_step(lfsr);
            lat  = 1 + lfsr[0];
            lfsr = lfsr_step(lfsr);
            lat  = lat + 2 * lfsr[0];
            due[t] = cyc + lat;
            eu_q.push_back(t);
        end

        // Tag offered before this edge's writeback frees anything
        new_tag = lowest_free();
        if (insert_i && wb_i.valid) begin
            for (int op = 0; op < 2; op++) begin
                key = inst_i.subwarp * 64 + inst_i.src[op];
                if (pend_v[key] && pend_t[key] == wb_i.tag) begin
                    n_fwd++;
                end
            end
        end
        if (wb_i.valid) begin
            t = wb_i.tag;
            busy[t] = 1'b0;
            for (int k = 0; k < 256; k++) begin
                if (pend_v[k] && pend_t[k] == t) begin
                    pend_v[k] = 1'b0;
                end
            end
            // Wake every operand waiting on this producer
            for (int i = 0; i < NUM_TAGS; i++) begin
                for (int op = 0; op < 2; op++) begin
                    if (busy[i] && dep_v[i][op] && dep_t[i][op] == t) begin
                        dep_v[i][op] = 1'b0;
                        ready_at[i]  = cyc;
                    end
                end
            end
        end
        if (insert_i) begin
            check(int'(new_tag >= 0), 1, "free tag on insert");
            if (new_tag >= 0) begin
                n_ins++;
                busy[new_tag]     = 1'b1;
                sent[new_tag]     = 1'b0;
                m_sw[new_tag]     = inst_i.subwarp;
                m_dst[new_tag]    = inst_i.dst;
                ready_at[new_tag] = cyc;
                for (int op = 0; op < 2; op++) begin
                    key = inst_i.subwarp * 64 + inst_i.src[op];
                    dep_v[new_tag][op] = pend_v[key];
                    dep_t[new_tag][op] = pend_t[key];
                end
                // Newest writer of dst wins
                key = inst_i.subwarp * 64 + inst_i.dst;
                pend_v[key] = 1'b1;
                pend_t[key] = new_tag;
            end
        end

        // EU picks the oldest due tag, one per cycle
        wb_nx_v = 1'b0;
        wb_nx_t = 0;
        qi      = 0;
        if (hold_cnt > 0) begin
            hold_cnt--;
        end else begin
            for (int i = 0; i < eu_q.size() && !wb_nx_v; i++) begin
                if (due[eu_q[i]] <= cyc) begin
                    wb_nx_v = 1'b1;
                    wb_nx_t = eu_q[i];
                    qi      = i;
                end
            end
            if (wb_nx_v) begin
                eu_q.delete(qi);
            end
        end

        // Decoder side
        ins_nx = 1'b0;
        cmd    = '0;
        if (idle_cnt > 0) begin
            idle_cnt--;
        end else if (cmd_idx < n_cmds) begin
            cmd = cmds[cmd_idx];
            case (cmd[31:28])
                4'h1, 4'h5: begin
                    key    = cmd[27:24] * 64 + cmd[15:8];
                    fwd_ok = wb_nx_v && pend_v[key] && pend_t[key] == wb_nx_t;
                    // Space after this edge, as the model sees it
                    if (n_busy() < NUM_TAGS && n_pend() < NUM_TAGS
                        && (cmd[31:28] == 4'h1 || fwd_ok)) begin
                        ins_nx = 1'b1;
                        cmd_idx++;
                    end
                end
                4'h2: begin
                    idle_cnt = cmd[7:0];
                    cmd_idx++;
                end
                4'h3: begin
                    hold_cnt = cmd[7:0];
                    cmd_idx++;
                end
                4'h4: begin
                    if (n_busy() == 0) begin
                        $display("test %0d done at cycle %0d, %0d errors so far",
                                 cmd[7:0], cyc, errors);
                        cmd_idx++;
                    end
                end
                default: begin
                    $display("unknown command %h at entry %0d", cmd, cmd_idx);
                    errors++;
                    cmd_idx++;
                end
            endcase
        end

        insert_i <= ins_nx;
        if (ins_nx) begin
            inst_i.subwarp <= cmd[25:24];
            inst_i.dst     <= cmd[21:16];
            inst_i.src[0]  <= cmd[13:8];
            inst_i.src[1]  <= cmd[5:0];
        end
        wb_i.valid <= wb_nx_v;
        wb_i.tag   <= issue_pkg::tag_t'(wb_nx_t);
    endtask

    // Run limit from the command count
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            wd_cycles++;
            if (wd_cycles > limit) begin
                $display("timeout after %0d cycles at command %0d of %0d",
                         wd_cycles, cmd_idx, n_cmds);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    // ################################################
    // Main sequence
    // ################################################

    initial begin
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        insert_i  = 1'b0;
        inst_i    = '0;
        wb_i      = '0;
        lfsr      = 32'hfbe58e98;
        cyc       = 0;
        wd_cycles = 0;
        errors    = 0;
        checks    = 0;
        n_fwd     = 0;
        n_ins     = 0;
        cmd_idx   = 0;
        idle_cnt  = 0;
        hold_cnt  = 0;
        for (int i = 0; i < MAX_CMDS; i++) begin
            cmds[i] = '0;
        end
        $readmemh("issue_testdata.txt", cmds);
        n_cmds = 0;
        while (n_cmds < MAX_CMDS && cmds[n_cmds][31:28] != 4'h0) begin
            n_cmds++;
        end
        limit = 40 * n_cmds + 200;
        if (n_cmds == 0) begin
            $display("no commands read from issue_testdata.txt");
            errors++;
        end

        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        while (cmd_idx < n_cmds) begin
            @(posedge clk_i);
            run_cycle();
        end
        // A few more edges so the last outputs get checked
        repeat (4) begin
            @(posedge clk_i);
            run_cycle();
        end

        $display("%0d checks, %0d errors, %0d inserts, %0d forwarded",
                 checks, errors, n_ins, n_fwd);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
issue_pkg.sv
tag_pool.sv
reg_table.sv
wait_buffer.sv
issue_stage.sv
tb_issue_stage.sv

/* issue_testdata.txt */
// kind(1) subwarp(1) dst(2) src0(2) src1(2), all hex, one command per line
// kind 1 insert, 2 idle count, 3 EU hold count, 4 end of test, 5 insert on producer writeback
10012829 // test 1 independent, sw0 r1 <- r40 r41
1002282a // sw0 r2 <- r40 r42
11012829 // sw1 r1 <- r40 r41
40000001
10050607 // test 2 true deps, sw0 r5 <- r6 r7
10080505 // sw0 r8 <- r5 r5
11090506 // sw1 r9 <- r5 r6, other subwarp
100a0805 // sw0 r10 <- r8 r5
40000002
120c0000 // test 3 write after write, sw2 r12 first write
120d0000 // sw2 r13
120c0d0d // sw2 r12 second write, waits on r13
120e0c0c // sw2 r14 reads the second r12
40000003
30000028 // test 4 capacity, EU holds 40 cycles
10100000
10110000
10120000
10130000
11100000
11110000
11120000
11130000
12100000 // ninth, waits for a writeback
40000004
13140000 // test 5 forwarding, sw3 r20
53151414 // sw3 r21 <- r20, inserted on its writeback
20000003 // idle gap
53161515 // sw3 r22 <- r21, inserted on its writeback
40000005
